// ==== hdl/mpmc_pkg.sv ====
package mpmc_pkg;

	// ========================================
	// Widths and command codes
	// ========================================
	localparam int MEM_WIDTH      = 128;
	localparam int MEM_BYTES      = MEM_WIDTH / 8;
	localparam int ADDR_WIDTH     = 32;
	localparam int APP_ADDR_WIDTH = 29;
	localparam int NUM_PORTS      = 2;

	localparam logic [2:0] CMD_WRITE = 3'd0;
	localparam logic [2:0] CMD_READ  = 3'd1;

	// ========================================
	// Bus types
	// ========================================
	// Narrow ports use only the low bits of sel and dat
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [MEM_BYTES-1:0]  sel;
		logic [ADDR_WIDTH-1:0] adr;
		logic [MEM_WIDTH-1:0]  dat;
	} wb_req_t;

	typedef struct packed {
		logic                 ack;
		logic                 err;
		logic [MEM_WIDTH-1:0] dat;
	} wb_rsp_t;

	// One memory line, seen as byte lanes or as 32-bit words
	typedef union packed {
		logic [MEM_BYTES-1:0][7:0]     bytes;
		logic [MEM_WIDTH/32-1:0][31:0] words;
	} mem_word_u;

	typedef struct packed {
		logic                                      valid;
		logic                                      we;
		logic [ADDR_WIDTH-$clog2(MEM_BYTES)-1:0]   line_adr;
		mem_word_u                                 data;
		logic [MEM_BYTES-1:0]                      mask;
	} port_cmd_t;

	typedef struct packed {
		logic                      en;
		logic [2:0]                cmd;
		logic [APP_ADDR_WIDTH-1:0] addr;
		logic [MEM_WIDTH-1:0]      wdf_data;
		logic [MEM_BYTES-1:0]      wdf_mask;
		logic                      wdf_wren;
		logic                      wdf_end;
	} app_req_t;

	typedef struct packed {
		logic                 rdy;
		logic                 wdf_rdy;
		logic [MEM_WIDTH-1:0] rd_data;
		logic                 rd_data_valid;
		logic                 rd_data_end;
	} app_rsp_t;

	typedef enum logic [3:0] {
		IDLE       = 4'd0,
		SETUP      = 4'd1,
		WRITE_DATA = 4'd2,
		WRITE_CMD  = 4'd3,
		READ_CMD   = 4'd4,
		READ_WAIT  = 4'd5,
		DONE       = 4'd6
	} fsm_state_e;

endpackage

// ==== hdl/mpmc_arbiter.sv ====
`timescale 1ns/1ps

module mpmc_arbiter import mpmc_pkg::*; #(
	parameter int ELEVATE_PERIOD = 64
) (
	input  logic      mem_ui_clk,
	input  logic      mem_ui_rst,
	input  port_cmd_t port0_cmd_i,
	input  port_cmd_t port1_cmd_i,
	input  logic      idle_i,
	output logic      grant_valid_o,
	output logic      grant_o
);

	localparam int               CNT_W    = $clog2(ELEVATE_PERIOD);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ELEVATE_PERIOD - 1);

	logic [NUM_PORTS-1:0] req;
	logic [CNT_W-1:0]     grant_cnt;
	logic                 elevate;
	logic                 granted;
	logic                 pick;

	assign req = {port1_cmd_i.valid, port0_cmd_i.valid};

	// Priority flips once per period so the CPU port is never starved
	assign elevate = (grant_cnt == CNT_LAST);

	always_comb begin
		if (elevate && req[1])
			pick = 1'b1;
		else if (req[0])
			pick = 1'b0;
		else
			pick = 1'b1;
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			grant_valid_o <= 1'b0;
			grant_o       <= 1'b0;
			granted       <= 1'b0;
			grant_cnt     <= '0;
		end else begin
			grant_valid_o <= 1'b0;
			// Sequencer has taken the grant once it leaves IDLE
			if (!idle_i) begin
				granted <= 1'b0;
			end else if (!granted && (|req)) begin
				grant_valid_o <= 1'b1;
				grant_o       <= pick;
				granted       <= 1'b1;
				if (elevate)
					grant_cnt <= '0;
				else
					grant_cnt <= grant_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/mpmc_lane_format.sv ====
`timescale 1ns/1ps

module mpmc_lane_format import mpmc_pkg::*; #(
	parameter int PORT_WIDTH = 32
) (
	input  logic      mem_ui_clk,
	input  logic      mem_ui_rst,
	input  wb_req_t   wb_req_i,
	input  logic      done_i,
	input  logic      timeout_i,
	input  logic      done_port_i,
	input  mem_word_u rd_word_i,
	output port_cmd_t cmd_o,
	output wb_rsp_t   wb_rsp_o
);

	localparam int   OFF_W      = $clog2(MEM_BYTES);
	localparam int   SEL_W      = PORT_WIDTH / 8;
	localparam int   PORT_WORDS = PORT_WIDTH / 32;
	// The graphics port is the only full-width one
	localparam logic PORT_IDX   = (PORT_WIDTH == MEM_WIDTH) ? 1'b0 : 1'b1;

	logic                 req;
	logic                 mine;
	logic                 ack_q;
	logic                 err_q;
	logic [OFF_W-1:0]     byte_off;
	logic [MEM_BYTES-1:0] lane_sel;
	mem_word_u            rd_lane;
	mem_word_u            rd_q;

	assign req      = wb_req_i.cyc && wb_req_i.stb;
	assign mine     = (done_port_i == PORT_IDX);
	// First byte of the lane picked by the low address bits
	assign byte_off = wb_req_i.adr[OFF_W-1:0] & OFF_W'(~(SEL_W - 1));
	assign lane_sel = MEM_BYTES'(wb_req_i.sel[SEL_W-1:0]);

	// ========================================
	// Request toward the sequencer
	// ========================================
	assign cmd_o.valid    = req && !(ack_q || err_q);
	assign cmd_o.we       = wb_req_i.we;
	assign cmd_o.line_adr = wb_req_i.adr[ADDR_WIDTH-1:OFF_W];
	// Narrow data is repeated across every lane
	assign cmd_o.data     = {(MEM_WIDTH / PORT_WIDTH){wb_req_i.dat[PORT_WIDTH-1:0]}};
	// A set mask bit disables that byte, reads enable all
	assign cmd_o.mask     = wb_req_i.we ? ~(lane_sel << byte_off) : '0;

	// ========================================
	// Read lane extraction
	// ========================================
	always_comb begin
		logic [OFF_W-3:0] w_idx;
		logic [OFF_W-1:0] b_idx;
		rd_lane = '0;
		w_idx   = '0;
		b_idx   = '0;
		if (PORT_WIDTH >= 32) begin
			// Word wide ports move whole 32-bit words
			for (int i = 0; i < PORT_WORDS; i++) begin
				w_idx = byte_off[OFF_W-1:2] + (OFF_W-2)'(i);
				rd_lane.words[i] = rd_word_i.words[w_idx];
			end
		end else begin
			for (int i = 0; i < SEL_W; i++) begin
				b_idx = byte_off + OFF_W'(i);
				rd_lane.bytes[i] = rd_word_i.bytes[b_idx];
			end
		end
	end

	// Response follows the sequencer strobe by one cycle
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= done_i && mine;
			err_q <= timeout_i && mine;
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (done_i && mine)
			rd_q <= rd_lane;
	end

	// Strobes drop as soon as the master ends the cycle
	assign wb_rsp_o.ack = ack_q && req;
	assign wb_rsp_o.err = err_q && req;
	assign wb_rsp_o.dat = rd_q;

endmodule

// ==== hdl/mpmc_cmd_fsm.sv ====
`timescale 1ns/1ps

module mpmc_cmd_fsm import mpmc_pkg::*; #(
	parameter int TIMEOUT_CYCLES = 512
) (
	input  logic      mem_ui_clk,
	input  logic      mem_ui_rst,
	input  logic      calib_complete_i,
	input  logic      grant_valid_i,
	input  logic      grant_i,
	input  port_cmd_t port0_cmd_i,
	input  port_cmd_t port1_cmd_i,
	input  app_rsp_t  app_rsp_i,
	output app_req_t  app_req_o,
	output logic      idle_o,
	output logic      done_o,
	output logic      timeout_o,
	output logic      done_port_o,
	output mem_word_u rd_word_o
);

	localparam int              TO_W    = $clog2(TIMEOUT_CYCLES);
	localparam logic [TO_W-1:0] TO_LAST = TO_W'(TIMEOUT_CYCLES - 1);

	fsm_state_e      state;
	fsm_state_e      next_state;
	port_cmd_t       cmd_q;
	logic            port_q;
	logic            timed_out;
	logic            hung;
	logic [TO_W-1:0] to_cnt;
	mem_word_u       rd_word_q;

	// Too long outside IDLE, the app side is not answering
	assign hung = (state != IDLE) && (state != DONE) && (to_cnt == TO_LAST);

	// ========================================
	// State machine
	// ========================================
	always_comb begin
		next_state = state;
		case (state)
			IDLE:
				if (grant_valid_i)
					next_state = SETUP;
			SETUP:
				next_state = cmd_q.we ? WRITE_DATA : READ_CMD;
			WRITE_DATA:
				if (app_rsp_i.wdf_rdy)
					next_state = WRITE_CMD;
			WRITE_CMD:
				if (app_rsp_i.rdy)
					next_state = DONE;
			READ_CMD:
				if (app_rsp_i.rdy)
					next_state = READ_WAIT;
			READ_WAIT:
				if (app_rsp_i.rd_data_valid)
					next_state = DONE;
			// One cycle gap so the master can drop stb
			DONE:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
		// A hung transfer still ends through DONE, flagged as timeout
		if (hung)
			next_state = DONE;
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			state     <= IDLE;
			to_cnt    <= '0;
			timed_out <= 1'b0;
			port_q    <= 1'b0;
		end else begin
			state <= next_state;
			if (state == IDLE) begin
				to_cnt    <= '0;
				timed_out <= 1'b0;
			end else begin
				to_cnt <= to_cnt + 1'b1;
			end
			if (hung)
				timed_out <= 1'b1;
			if (state == IDLE && grant_valid_i)
				port_q <= grant_i;
		end
	end

	// Granted request and read data
	always_ff @(posedge mem_ui_clk) begin
		if (state == IDLE && grant_valid_i)
			cmd_q <= grant_i ? port1_cmd_i : port0_cmd_i;
		if (state == READ_WAIT && app_rsp_i.rd_data_valid)
			rd_word_q <= app_rsp_i.rd_data;
	end

	// ========================================
	// Outputs
	// ========================================
	assign idle_o      = (state == IDLE) && calib_complete_i;
	assign done_o      = (state == DONE) && !timed_out;
	assign timeout_o   = (state == DONE) && timed_out;
	assign done_port_o = port_q;
	assign rd_word_o   = rd_word_q;

	always_comb begin
		app_req_o.en       = (state == WRITE_CMD) || (state == READ_CMD);
		app_req_o.cmd      = cmd_q.we ? CMD_WRITE : CMD_READ;
		// Line address back to byte addressing
		app_req_o.addr     = APP_ADDR_WIDTH'({cmd_q.line_adr, {$clog2(MEM_BYTES){1'b0}}});
		app_req_o.wdf_data = cmd_q.data;
		app_req_o.wdf_mask = cmd_q.mask;
		// Single strip, so the first beat is also the last
		app_req_o.wdf_wren = (state == WRITE_DATA);
		app_req_o.wdf_end  = (state == WRITE_DATA);
	end

endmodule

// ==== hdl/mpmc_top.sv ====
`timescale 1ns/1ps

module mpmc_top import mpmc_pkg::*; #(
	parameter int ELEVATE_PERIOD = 64,
	parameter int TIMEOUT_CYCLES = 512
) (
	input  logic     mem_ui_clk,
	input  logic     mem_ui_rst,
	input  logic     calib_complete_i,
	input  wb_req_t  wb0_req_i,
	input  wb_req_t  wb1_req_i,
	input  app_rsp_t app_rsp_i,
	output wb_rsp_t  wb0_rsp_o,
	output wb_rsp_t  wb1_rsp_o,
	output app_req_t app_req_o
);

	port_cmd_t port0_cmd;
	port_cmd_t port1_cmd;
	logic      grant_valid;
	logic      grant;
	logic      idle;
	logic      done;
	logic      timeout;
	logic      done_port;
	mem_word_u rd_word;

	// ========================================
	// Port formatters
	// ========================================
	// Graphics port
	mpmc_lane_format #(
		.PORT_WIDTH(128)
	) u_port0 (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.wb_req_i   (wb0_req_i),
		.done_i     (done),
		.timeout_i  (timeout),
		.done_port_i(done_port),
		.rd_word_i  (rd_word),
		.cmd_o      (port0_cmd),
		.wb_rsp_o   (wb0_rsp_o)
	);

	// CPU port
	mpmc_lane_format #(
		.PORT_WIDTH(32)
	) u_port1 (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.wb_req_i   (wb1_req_i),
		.done_i     (done),
		.timeout_i  (timeout),
		.done_port_i(done_port),
		.rd_word_i  (rd_word),
		.cmd_o      (port1_cmd),
		.wb_rsp_o   (wb1_rsp_o)
	);

	// ========================================
	// Arbitration and sequencing
	// ========================================
	mpmc_arbiter #(
		.ELEVATE_PERIOD(ELEVATE_PERIOD)
	) u_arb (
		.mem_ui_clk   (mem_ui_clk),
		.mem_ui_rst   (mem_ui_rst),
		.port0_cmd_i  (port0_cmd),
		.port1_cmd_i  (port1_cmd),
		.idle_i       (idle),
		.grant_valid_o(grant_valid),
		.grant_o      (grant)
	);

	mpmc_cmd_fsm #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) u_seq (
		.mem_ui_clk      (mem_ui_clk),
		.mem_ui_rst      (mem_ui_rst),
		.calib_complete_i(calib_complete_i),
		.grant_valid_i   (grant_valid),
		.grant_i         (grant),
		.port0_cmd_i     (port0_cmd),
		.port1_cmd_i     (port1_cmd),
		.app_rsp_i       (app_rsp_i),
		.app_req_o       (app_req_o),
		.idle_o          (idle),
		.done_o          (done),
		.timeout_o       (timeout),
		.done_port_o     (done_port),
		.rd_word_o       (rd_word)
	);

endmodule

// ==== testbench/mig_model.sv ====
`timescale 1ns/1ps

module mig_model import mpmc_pkg::*; #(
	parameter int LINES      = 256,
	parameter int RD_LATENCY = 3
) (
	input  logic        mem_ui_clk,
	input  logic        mem_ui_rst,
	input  app_req_t    app_req_i,
	input  logic        stall_set_i,
	input  logic [15:0] stall_len_i,
	output app_rsp_t    app_rsp_o
);

	localparam int LINE_W = $clog2(LINES);

	logic [MEM_WIDTH-1:0] mem [LINES];
	logic [MEM_WIDTH-1:0] wbuf;
	logic [MEM_BYTES-1:0] wmask;
	logic [LINE_W-1:0]    cmd_line;
	logic [LINE_W-1:0]    rd_line;
	logic [7:0]           rd_wait;
	logic [15:0]          stall_cnt;
	logic                 ready;
	logic                 rd_valid;
	logic [MEM_WIDTH-1:0] rd_data;

	// Both ready lines drop together while a stall is running
	assign ready    = (stall_cnt == '0);
	assign cmd_line = app_req_i.addr[LINE_W+3:4];

	assign app_rsp_o = '{
		rdy:           ready,
		wdf_rdy:       ready,
		rd_data:       rd_data,
		rd_data_valid: rd_valid,
		rd_data_end:   rd_valid
	};

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			stall_cnt <= '0;
			rd_wait   <= '0;
			rd_valid  <= 1'b0;
			// Each word carries its line and word index
			for (int i = 0; i < LINES; i++)
				for (int w = 0; w < MEM_WIDTH / 32; w++)
					mem[i][w*32 +: 32] <= {8'(i), 8'(w), 16'h5a3c};
		end else begin
			rd_valid <= 1'b0;
			if (stall_set_i)
				stall_cnt <= stall_len_i;
			else if (!ready)
				stall_cnt <= stall_cnt - 1'b1;
			if (app_req_i.wdf_wren && ready) begin
				wbuf  <= app_req_i.wdf_data;
				wmask <= app_req_i.wdf_mask;
			end
			if (app_req_i.en && ready) begin
				if (app_req_i.cmd == CMD_WRITE) begin
					// Set mask bit means the byte keeps its old value
					for (int b = 0; b < MEM_BYTES; b++)
						if (!wmask[b])
							mem[cmd_line][b*8 +: 8] <= wbuf[b*8 +: 8];
				end else begin
					rd_line <= cmd_line;
					rd_wait <= 8'(RD_LATENCY);
				end
			end else if (rd_wait != '0) begin
				rd_wait <= rd_wait - 1'b1;
				if (rd_wait == 8'd1) begin
					rd_valid <= 1'b1;
					rd_data  <= mem[rd_line];
				end
			end
		end
	end

endmodule

// ==== testbench/tb_mpmc.sv ====
`timescale 1ns/1ps

module tb_mpmc import mpmc_pkg::*; ();

	localparam int CLK_PERIOD     = 100;
	localparam int ELEVATE_PERIOD = 64;
	localparam int TIMEOUT_CYCLES = 512;
	localparam int WAIT_LIMIT     = 2000;

	logic        mem_ui_clk;
	logic        mem_ui_rst;
	logic        calib_complete;
	wb_req_t     wb0_req;
	wb_req_t     wb1_req;
	wb_rsp_t     wb0_rsp;
	wb_rsp_t     wb1_rsp;
	app_req_t    app_req;
	app_rsp_t    app_rsp;
	logic        stall_set;
	logic [15:0] stall_len;

	logic [31:0]  lcg_state;
	int           test_errs;
	int           grant_cnt;
	// Lines whose every byte is known to the testbench
	logic [127:0] shadow [int];

	mpmc_top #(
		.ELEVATE_PERIOD(ELEVATE_PERIOD),
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) u_dut (
		.mem_ui_clk      (mem_ui_clk),
		.mem_ui_rst      (mem_ui_rst),
		.calib_complete_i(calib_complete),
		.wb0_req_i       (wb0_req),
		.wb1_req_i       (wb1_req),
		.app_rsp_i       (app_rsp),
		.wb0_rsp_o       (wb0_rsp),
		.wb1_rsp_o       (wb1_rsp),
		.app_req_o       (app_req)
	);

	mig_model #(
		.RD_LATENCY(3)
	) u_mem (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.app_req_i  (app_req),
		.stall_set_i(stall_set),
		.stall_len_i(stall_len),
		.app_rsp_o  (app_rsp)
	);

	initial begin
		mem_ui_clk = 1'b0;
		forever #(CLK_PERIOD / 2) mem_ui_clk = ~mem_ui_clk;
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic drive_req(input int port, input logic we, input logic [31:0] adr,
			input logic [15:0] sel, input logic [127:0] dat);
		wb_req_t r;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we  = we;
		r.sel = sel;
		r.adr = adr;
		r.dat = dat;
		if (port == 0)
			wb0_req = r;
		else
			wb1_req = r;
	endtask

	task automatic release_req(input int port);
		if (port == 0)
			wb0_req = '0;
		else
			wb1_req = '0;
	endtask

	// Byte off+i takes data byte i where sel[i] is set
	task automatic track_write(input int port, input logic [31:0] adr,
			input logic [15:0] sel, input logic [127:0] dat);
		int           key;
		int           nb;
		int           off;
		logic [127:0] line;
		key = int'(adr[31:4]);
		nb  = (port == 0) ? MEM_BYTES : 4;
		off = (port == 0) ? 0 : int'(adr[3:2]) * 4;
		if (port == 0 && sel == 16'hffff) begin
			shadow[key] = dat;
		end else if (shadow.exists(key)) begin
			line = shadow[key];
			for (int i = 0; i < nb; i++)
				if (sel[i])
					line[(off+i)*8 +: 8] = dat[i*8 +: 8];
			shadow[key] = line;
		end
	endtask

	function automatic logic [127:0] expected_read(input int port, input logic [31:0] adr);
		logic [127:0] line;
		line = shadow[int'(adr[31:4])];
		if (port == 0)
			return line;
		return {96'b0, line[int'(adr[3:2])*32 +: 32]};
	endfunction

	task automatic transfer(input int port, input logic we, input logic [31:0] adr,
			input logic [15:0] sel, input logic [127:0] dat,
			output logic got_err, output logic [127:0] rdata);
		int      cycles;
		logic    done;
		wb_rsp_t rsp;
		done    = 1'b0;
		got_err = 1'b0;
		rdata   = '0;
		cycles  = 0;
		drive_req(port, we, adr, sel, dat);
		while (!done && cycles < WAIT_LIMIT) begin
			@(posedge mem_ui_clk);
			#1;
			cycles++;
			// Single strip writes mark every data beat as the last one
			check_value("app_req.wdf_end", 128'(app_req.wdf_end), 128'(app_req.wdf_wren));
			rsp = (port == 0) ? wb0_rsp : wb1_rsp;
			if (rsp.ack || rsp.err) begin
				done    = 1'b1;
				got_err = rsp.err;
				rdata   = rsp.dat;
			end
		end
		release_req(port);
		grant_cnt++;
		if (!done) begin
			$display("Port %0d gave neither ack nor err within %0d cycles", port, WAIT_LIMIT);
			test_errs++;
		end
		@(posedge mem_ui_clk);
		#1;
	endtask

	// Both ports request in the same cycle and the first to finish is reported
	task automatic run_pair(input logic [31:0] adr, input logic [15:0] sel,
			input logic [127:0] dat0, input logic [31:0] dat1, output int first);
		int         cycles;
		logic [1:0] seen;
		first  = -1;
		seen   = 2'b00;
		cycles = 0;
		drive_req(0, 1'b1, adr, sel, dat0);
		drive_req(1, 1'b1, adr + 32'h10, 16'h000f, {96'b0, dat1});
		while (seen != 2'b11 && cycles < 2 * WAIT_LIMIT) begin
			@(posedge mem_ui_clk);
			#1;
			cycles++;
			if (!seen[0] && (wb0_rsp.ack || wb0_rsp.err)) begin
				seen[0] = 1'b1;
				release_req(0);
				if (first < 0)
					first = 0;
			end
			if (!seen[1] && (wb1_rsp.ack || wb1_rsp.err)) begin
				seen[1] = 1'b1;
				release_req(1);
				if (first < 0)
					first = 1;
			end
		end
		release_req(0);
		release_req(1);
		grant_cnt += 2;
		if (seen != 2'b11) begin
			$display("Paired request did not finish within %0d cycles", 2 * WAIT_LIMIT);
			test_errs++;
		end else begin
			track_write(0, adr, sel, dat0);
			track_write(1, adr + 32'h10, 16'h000f, {96'b0, dat1});
		end
		@(posedge mem_ui_clk);
		#1;
	endtask

	task automatic apply_stall(input logic [15:0] cycles);
		stall_len = cycles;
		stall_set = 1'b1;
		@(posedge mem_ui_clk);
		#1;
		stall_set = 1'b0;
	endtask

	// Pairs across grant indices 63 and 127 with single writes to keep pairs aligned
	task automatic elevate_sweep();
		int           first;
		int           predicted;
		int           lifted;
		logic         err;
		logic [127:0] rdata;
		lifted = 0;
		while (grant_cnt <= 2 * ELEVATE_PERIOD) begin
			if (grant_cnt % ELEVATE_PERIOD == ELEVATE_PERIOD - 2) begin
				transfer(1, 1'b1, 32'h800, 16'h000f, {96'b0, next_rand()}, err, rdata);
				check_value("wb1_rsp.err", 128'(err), 128'(0));
			end else begin
				predicted = (grant_cnt % ELEVATE_PERIOD == ELEVATE_PERIOD - 1) ? 1 : 0;
				run_pair(32'h900, 16'hffff,
					{next_rand(), next_rand(), next_rand(), next_rand()}, next_rand(), first);
				check_value("first_ack_port", 128'(first), 128'(predicted));
				if (first == 1)
					lifted++;
			end
		end
		check_value("port1_first_count", 128'(lifted), 128'(2));
	endtask

	// ========================================
	// Test file runner
	// ========================================
	initial begin
		int           fd;
		int           n;
		int           test_no;
		int           pass_cnt;
		int           fail_cnt;
		int           port;
		int           first;
		string        line;
		string        op;
		logic [31:0]  addr;
		logic [15:0]  sel;
		logic [127:0] data;
		logic [127:0] expected;
		logic [127:0] rdata;
		logic         got_err;

		mem_ui_rst     = 1'b1;
		calib_complete = 1'b0;
		wb0_req        = '0;
		wb1_req        = '0;
		stall_set      = 1'b0;
		stall_len      = '0;
		lcg_state      = 32'h75685721;
		grant_cnt      = 0;
		test_errs      = 0;
		test_no        = 0;
		pass_cnt       = 0;
		fail_cnt       = 0;

		repeat (8) @(posedge mem_ui_clk);
		#1;
		mem_ui_rst = 1'b0;
		repeat (4) @(posedge mem_ui_clk);
		#1;
		calib_complete = 1'b1;

		fd = $fopen("testbench/mpmc_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file testbench/mpmc_tests.txt");
			fail_cnt++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) begin
					n = $sscanf(line, "%s %d %h %h %h %h", op, port, addr, sel, data, expected);
					if (n == 6 && op != "#") begin
						test_errs = 0;
						test_no++;
						if (op == "W") begin
							transfer(port, 1'b1, addr, sel, data, got_err, rdata);
							check_value("wb_rsp.err", 128'(got_err), 128'(expected[0]));
							if (!got_err)
								track_write(port, addr, sel, data);
						end else if (op == "R") begin
							transfer(port, 1'b0, addr, sel, '0, got_err, rdata);
							check_value("wb_rsp.err", 128'(got_err), 128'(0));
							check_value((port == 0) ? "wb0_rsp.dat" : "wb1_rsp.dat",
								rdata, expected);
							if (shadow.exists(int'(addr[31:4])))
								check_value("model_dat", rdata, expected_read(port, addr));
						end else if (op == "P") begin
							expected = (grant_cnt % ELEVATE_PERIOD == ELEVATE_PERIOD - 1) ?
								128'(1) : 128'(0);
							run_pair(addr, sel, data, data[31:0], first);
							check_value("first_ack_port", 128'(first), expected);
						end else if (op == "S") begin
							apply_stall(addr[15:0]);
						end else if (op == "E") begin
							elevate_sweep();
						end else begin
							$display("Unknown opcode %s in the test file", op);
							test_errs++;
						end
						$display("Test %0d %s port %0d addr %h: %s", test_no, op, port, addr,
							(test_errs == 0) ? "ok" : "failed");
						if (test_errs == 0)
							pass_cnt++;
						else
							fail_cnt++;
					end
				end
			end
			$fclose(fd);
		end

		$display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== testbench/mpmc_tests.txt ====
# op port addr sel data expected (port decimal, the rest hex)
# W write (expected 1 = err), R read, P paired writes, S stall for addr cycles, E elevate sweep
W 0 00000100 ffff 00112233445566778899aabbccddeeff 0
R 0 00000100 ffff 0 00112233445566778899aabbccddeeff
W 0 00000200 ffff fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0 0
W 1 00000200 0001 a1a2a3a4 0
W 1 00000204 0006 b1b2b3b4 0
W 1 00000208 000c c1c2c3c4 0
W 1 0000020c 000a d1d2d3d4 0
R 1 00000200 000f 0 f3f2f1a4
R 1 00000204 000f 0 f7b2b3f4
R 1 00000208 000f 0 c1c2f9f8
R 1 0000020c 000f 0 d1fed3fc
R 0 00000200 ffff 0 d1fed3fcc1c2f9f8f7b2b3f4f3f2f1a4
P 0 00000300 ffff 0123456789abcdeffedcba9876543210 0
R 0 00000300 ffff 0 0123456789abcdeffedcba9876543210
R 1 00000310 000f 0 76543210
S 0 00000064 0 0 0
W 1 00000404 000f 55aa55aa 0
R 1 00000404 000f 0 55aa55aa
S 0 00000064 0 0 0
R 0 00000100 ffff 0 00112233445566778899aabbccddeeff
S 0 00000258 0 0 0
W 0 00000500 ffff deadbeefdeadbeefdeadbeefdeadbeef 1
W 0 00000500 ffff 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
R 0 00000500 ffff 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0
P 0 00000600 ffff 1111222233334444555566667777cafe 0
E 0 0 0 0 0
R 0 00000200 ffff 0 d1fed3fcc1c2f9f8f7b2b3f4f3f2f1a4

// ==== tb.f ====
hdl/mpmc_pkg.sv
hdl/mpmc_arbiter.sv
hdl/mpmc_lane_format.sv
hdl/mpmc_cmd_fsm.sv
hdl/mpmc_top.sv
testbench/mig_model.sv
testbench/tb_mpmc.sv

// ==== Makefile ====
# Verilator build for the two-port memory controller
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_mpmc
RTL_TOP   ?= mpmc_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?=
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP) $(VFLAGS)

# The run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary -j $(JOBS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) $(VFLAGS)
	$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
